// File: logic/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// words per line, also the refill burst length
`define LINE_WORDS 4

// number of direct-mapped lines
`define CACHE_SETS 16

// address split: tag | index | byte offset within line
`define OFFSET_W ($clog2(`LINE_WORDS) + $clog2(`MEM_DATA_W / 8))
`define INDEX_W ($clog2(`CACHE_SETS))
`define TAG_W (`MEM_ADDR_W - `INDEX_W - `OFFSET_W)

`endif

// File: logic/mem_pkg.sv
`include "mem_config.svh"

package mem_pkg;

  // access size as the cpu encodes it
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // request held by the controller, addr already physical
  typedef struct packed {
    logic                   wr;
    size_e                  size;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
  } cpu_req_t;

  // what the bridge has to do on axi
  typedef enum logic [1:0] {
    BUS_READ_SINGLE = 2'd0,
    BUS_READ_LINE   = 2'd1,
    BUS_WRITE       = 2'd2
  } bus_op_e;

  typedef struct packed {
    bus_op_e                  op;
    logic [`MEM_ADDR_W-1:0]   addr;
    logic [`MEM_DATA_W-1:0]   wdata;
    logic [`MEM_DATA_W/8-1:0] wstrb;
  } bus_req_t;

  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
    logic [2:0]             size;
  } axi_aw_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0]   data;
    logic [`MEM_DATA_W/8-1:0] strb;
    logic                     last;
  } axi_w_t;

  // both fsms share this scope, hence the prefixes
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_REFILL,
    CTRL_BYPASS_READ,
    CTRL_WRITE
  } ctrl_state_e;

  typedef enum logic [2:0] {
    BRG_IDLE,
    BRG_AR,
    BRG_R,
    BRG_AW_W,
    BRG_B
  } bridge_state_e;

endpackage

// File: logic/cache_store.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_store (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`INDEX_W-1:0]      lookup_index,
  input  logic [`TAG_W-1:0]        lookup_tag,
  output logic                     hit,
  output logic [`MEM_DATA_W-1:0]   hit_word,
  input  logic                     fill_en,
  input  logic [`OFFSET_W-3:0]     fill_word,
  input  logic [`MEM_DATA_W-1:0]   fill_data,
  input  logic                     wr_en,
  input  logic [`MEM_DATA_W/8-1:0] wr_strb,
  input  logic [`MEM_DATA_W-1:0]   wr_data
);

  logic [`CACHE_SETS-1:0] valid;
  logic [`TAG_W-1:0]      tag_arr  [`CACHE_SETS];
  logic [`MEM_DATA_W-1:0] data_arr [`CACHE_SETS][`LINE_WORDS];
  logic                   last_word;

  assign last_word = (fill_word == {(`OFFSET_W-2){1'b1}});

  assign hit      = valid[lookup_index] && (tag_arr[lookup_index] == lookup_tag);
  assign hit_word = data_arr[lookup_index][fill_word];

  // line becomes valid only once its final word is in
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill_en) begin
      valid[lookup_index] <= last_word;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_arr[lookup_index] <= lookup_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_arr[lookup_index][fill_word] <= fill_data;
    end else if (wr_en) begin
      // byte-masked update on a write hit
      for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
        if (wr_strb[b]) begin
          data_arr[lookup_index][fill_word][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  logic                     wr,
  input  mem_pkg::size_e           size,
  input  logic [`MEM_ADDR_W-1:0]   addr,
  input  logic [`MEM_DATA_W-1:0]   wdata,
  output logic                     addr_ok,
  output logic                     data_ok,
  output logic [`MEM_DATA_W-1:0]   rdata,
  // cache store
  output logic [`INDEX_W-1:0]      lookup_index,
  output logic [`TAG_W-1:0]        lookup_tag,
  input  logic                     hit,
  input  logic [`MEM_DATA_W-1:0]   hit_word,
  output logic                     fill_en,
  output logic [`OFFSET_W-3:0]     fill_word,
  output logic [`MEM_DATA_W-1:0]   fill_data,
  output logic                     wr_en,
  output logic [`MEM_DATA_W/8-1:0] wr_strb,
  output logic [`MEM_DATA_W-1:0]   wr_data,
  // bridge
  output mem_pkg::bus_req_t        bus_req,
  output logic                     bus_start,
  input  logic                     beat_valid,
  input  logic [`MEM_DATA_W-1:0]   beat_data,
  input  logic                     beat_last,
  input  logic                     bus_done
);

  mem_pkg::ctrl_state_e     state;
  mem_pkg::cpu_req_t        req_q;
  logic                     cached_q;
  logic                     seg_cached;
  logic [`MEM_ADDR_W-1:0]   paddr;
  logic [`OFFSET_W-3:0]     beat_cnt;
  logic [`OFFSET_W-3:0]     req_word;
  logic [`MEM_DATA_W/8-1:0] wstrb;
  logic                     read_hit;

  // fixed mips segment map, kseg0 cached, kseg1 uncached
  always_comb begin
    seg_cached = (addr[`MEM_ADDR_W-1 -: 3] == 3'b100);
    if (addr[`MEM_ADDR_W-1 -: 2] == 2'b10) begin
      paddr = {3'b000, addr[`MEM_ADDR_W-4:0]};
    end else begin
      paddr = addr;
    end
  end

  assign addr_ok = (state == mem_pkg::CTRL_IDLE);

  assign req_word     = req_q.addr[`OFFSET_W-1:2];
  assign lookup_index = req_q.addr[`OFFSET_W +: `INDEX_W];
  assign lookup_tag   = req_q.addr[`MEM_ADDR_W-1 -: `TAG_W];

  // byte lanes from size and low address bits
  always_comb begin
    case (req_q.size)
      mem_pkg::SIZE_BYTE: wstrb = 4'b0001 << req_q.addr[1:0];
      mem_pkg::SIZE_HALF: wstrb = req_q.addr[1] ? 4'b1100 : 4'b0011;
      default:            wstrb = 4'b1111;
    endcase
  end

  assign read_hit = !req_q.wr && cached_q && hit;

  // anything but a read hit goes out to the bus
  assign bus_start = (state == mem_pkg::CTRL_LOOKUP) && !read_hit;

  always_comb begin
    if (req_q.wr) begin
      bus_req.op = mem_pkg::BUS_WRITE;
    end else if (cached_q) begin
      bus_req.op = mem_pkg::BUS_READ_LINE;
    end else begin
      bus_req.op = mem_pkg::BUS_READ_SINGLE;
    end
    bus_req.addr  = req_q.addr;
    bus_req.wdata = req_q.wdata;
    bus_req.wstrb = wstrb;
  end

  // write-through, a resident line is patched too
  assign wr_en   = (state == mem_pkg::CTRL_LOOKUP) && req_q.wr && hit;
  assign wr_strb = wstrb;
  assign wr_data = req_q.wdata;

  assign fill_en   = (state == mem_pkg::CTRL_REFILL) && beat_valid;
  assign fill_data = beat_data;
  // word pointer: beat count while filling, request word otherwise
  assign fill_word = (state == mem_pkg::CTRL_REFILL) ? beat_cnt : req_word;

  always_ff @(posedge clk) begin
    if (req && addr_ok) begin
      req_q.wr    <= wr;
      req_q.size  <= size;
      req_q.addr  <= paddr;
      req_q.wdata <= wdata;
      cached_q    <= seg_cached;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mem_pkg::CTRL_IDLE;
      data_ok  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      data_ok <= 1'b0;
      case (state)
        mem_pkg::CTRL_IDLE: begin
          if (req) begin
            state <= mem_pkg::CTRL_LOOKUP;
          end
        end
        mem_pkg::CTRL_LOOKUP: begin
          beat_cnt <= '0;
          if (req_q.wr) begin
            state <= mem_pkg::CTRL_WRITE;
          end else if (read_hit) begin
            data_ok <= 1'b1;
            state   <= mem_pkg::CTRL_IDLE;
          end else if (cached_q) begin
            state <= mem_pkg::CTRL_REFILL;
          end else begin
            state <= mem_pkg::CTRL_BYPASS_READ;
          end
        end
        mem_pkg::CTRL_REFILL: begin
          if (beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_last) begin
              data_ok <= 1'b1;
              state   <= mem_pkg::CTRL_IDLE;
            end
          end
        end
        default: begin
          // uncached read or write, wait for the bridge
          if (bus_done) begin
            data_ok <= 1'b1;
            state   <= mem_pkg::CTRL_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mem_pkg::CTRL_LOOKUP && read_hit) begin
      rdata <= hit_word;
    end else if (state == mem_pkg::CTRL_REFILL && beat_valid && beat_cnt == req_word) begin
      rdata <= beat_data;
    end else if (state == mem_pkg::CTRL_BYPASS_READ && beat_valid) begin
      rdata <= beat_data;
    end
  end

endmodule

// File: logic/axi_bridge.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module axi_bridge (
  input  logic                   clk,
  input  logic                   rst,
  input  mem_pkg::bus_req_t      bus_req,
  input  logic                   bus_start,
  output logic                   beat_valid,
  output logic [`MEM_DATA_W-1:0] beat_data,
  output logic                   beat_last,
  output logic                   bus_done,
  // axi read
  output mem_pkg::axi_ar_t       ar,
  output logic                   arvalid,
  input  logic                   arready,
  input  logic [`MEM_DATA_W-1:0] rdata_axi,
  input  logic                   rlast,
  input  logic                   rvalid,
  output logic                   rready,
  // axi write
  output mem_pkg::axi_aw_t       aw,
  output logic                   awvalid,
  input  logic                   awready,
  output mem_pkg::axi_w_t        w,
  output logic                   wvalid,
  input  logic                   wready,
  input  logic                   bvalid,
  output logic                   bready
);

  mem_pkg::bridge_state_e state;
  logic                   aw_done;
  logic                   w_done;

  // channel is finished when already dropped or accepted now
  assign aw_done = !awvalid || awready;
  assign w_done  = !wvalid || wready;

  assign beat_valid = (state == mem_pkg::BRG_R) && rvalid && rready;
  assign beat_data  = rdata_axi;
  assign beat_last  = rlast;

  // payloads latched at bus_start, held until the transaction is done
  always_ff @(posedge clk) begin
    if (state == mem_pkg::BRG_IDLE && bus_start) begin
      if (bus_req.op == mem_pkg::BUS_READ_LINE) begin
        ar.addr <= {bus_req.addr[`MEM_ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
        ar.len  <= 8'(`LINE_WORDS - 1);
      end else begin
        ar.addr <= bus_req.addr;
        ar.len  <= 8'd0;
      end
      // always full word beats, incr burst
      ar.size  <= 3'($clog2(`MEM_DATA_W / 8));
      ar.burst <= 2'b01;
      aw.addr  <= bus_req.addr;
      aw.size  <= 3'($clog2(`MEM_DATA_W / 8));
      w.data   <= bus_req.wdata;
      w.strb   <= bus_req.wstrb;
      w.last   <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mem_pkg::BRG_IDLE;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
      bus_done <= 1'b0;
    end else begin
      bus_done <= 1'b0;
      case (state)
        mem_pkg::BRG_IDLE: begin
          if (bus_start) begin
            if (bus_req.op == mem_pkg::BUS_WRITE) begin
              awvalid <= 1'b1;
              wvalid  <= 1'b1;
              state   <= mem_pkg::BRG_AW_W;
            end else begin
              arvalid <= 1'b1;
              state   <= mem_pkg::BRG_AR;
            end
          end
        end
        mem_pkg::BRG_AR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= mem_pkg::BRG_R;
          end
        end
        mem_pkg::BRG_R: begin
          if (rvalid && rlast) begin
            rready   <= 1'b0;
            bus_done <= 1'b1;
            state    <= mem_pkg::BRG_IDLE;
          end
        end
        mem_pkg::BRG_AW_W: begin
          // aw and w may complete in either order
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_done && w_done) begin
            bready <= 1'b1;
            state  <= mem_pkg::BRG_B;
          end
        end
        mem_pkg::BRG_B: begin
          if (bvalid) begin
            bready   <= 1'b0;
            bus_done <= 1'b1;
            state    <= mem_pkg::BRG_IDLE;
          end
        end
        default: begin
          state <= mem_pkg::BRG_IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/mem_unit.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_unit (
  input  logic                   clk,
  input  logic                   rst,
  // cpu sram-like side
  input  logic                   req,
  input  logic                   wr,
  input  mem_pkg::size_e         size,
  input  logic [`MEM_ADDR_W-1:0] addr,
  input  logic [`MEM_DATA_W-1:0] wdata,
  output logic                   addr_ok,
  output logic                   data_ok,
  output logic [`MEM_DATA_W-1:0] rdata,
  // axi read
  output mem_pkg::axi_ar_t       ar,
  output logic                   arvalid,
  input  logic                   arready,
  input  logic [`MEM_DATA_W-1:0] rdata_axi,
  input  logic                   rlast,
  input  logic                   rvalid,
  output logic                   rready,
  // axi write
  output mem_pkg::axi_aw_t       aw,
  output logic                   awvalid,
  input  logic                   awready,
  output mem_pkg::axi_w_t        w,
  output logic                   wvalid,
  input  logic                   wready,
  input  logic                   bvalid,
  output logic                   bready
);

  logic [`INDEX_W-1:0]         lookup_index;
  logic [`TAG_W-1:0]           lookup_tag;
  logic                        hit;
  logic [`MEM_DATA_W-1:0]      hit_word;
  logic                        fill_en;
  logic [`OFFSET_W-3:0]        fill_word;
  logic [`MEM_DATA_W-1:0]      fill_data;
  logic                        wr_en;
  logic [`MEM_DATA_W/8-1:0]    wr_strb;
  logic [`MEM_DATA_W-1:0]      wr_data;
  mem_pkg::bus_req_t           bus_req;
  logic                        bus_start;
  logic                        beat_valid;
  logic [`MEM_DATA_W-1:0]      beat_data;
  logic                        beat_last;
  logic                        bus_done;

  cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .wr           (wr),
    .size         (size),
    .addr         (addr),
    .wdata        (wdata),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .rdata        (rdata),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .hit          (hit),
    .hit_word     (hit_word),
    .fill_en      (fill_en),
    .fill_word    (fill_word),
    .fill_data    (fill_data),
    .wr_en        (wr_en),
    .wr_strb      (wr_strb),
    .wr_data      (wr_data),
    .bus_req      (bus_req),
    .bus_start    (bus_start),
    .beat_valid   (beat_valid),
    .beat_data    (beat_data),
    .beat_last    (beat_last),
    .bus_done     (bus_done)
  );

  cache_store u_store (
    .clk          (clk),
    .rst          (rst),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .hit          (hit),
    .hit_word     (hit_word),
    .fill_en      (fill_en),
    .fill_word    (fill_word),
    .fill_data    (fill_data),
    .wr_en        (wr_en),
    .wr_strb      (wr_strb),
    .wr_data      (wr_data)
  );

  axi_bridge u_bridge (
    .clk        (clk),
    .rst        (rst),
    .bus_req    (bus_req),
    .bus_start  (bus_start),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last),
    .bus_done   (bus_done),
    .ar         (ar),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata_axi  (rdata_axi),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready),
    .aw         (aw),
    .awvalid    (awvalid),
    .awready    (awready),
    .w          (w),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module axi_mem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_en,
  input  mem_pkg::axi_ar_t       ar,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [`MEM_DATA_W-1:0] rdata,
  output logic                   rlast,
  output logic                   rvalid,
  input  logic                   rready,
  input  mem_pkg::axi_aw_t       aw,
  input  logic                   awvalid,
  output logic                   awready,
  input  mem_pkg::axi_w_t        w,
  input  logic                   wvalid,
  output logic                   wready,
  output logic                   bvalid,
  input  logic                   bready,
  output int                     ar_count,
  output int                     aw_count,
  output mem_pkg::axi_ar_t       last_ar,
  output mem_pkg::axi_aw_t       last_aw,
  output mem_pkg::axi_w_t        last_w
);

  // holds written words only
  logic [31:0]     mem [logic [29:0]];
  logic            r_busy;
  logic [31:0]     r_addr;
  logic [7:0]      r_left;
  logic            aw_got;
  logic            w_got;

  // bus idle until the first reset edge
  initial begin
    arready <= 1'b0;
    rvalid  <= 1'b0;
    rlast   <= 1'b0;
    rdata   <= '0;
    awready <= 1'b0;
    wready  <= 1'b0;
    bvalid  <= 1'b0;
  end

  // unwritten words read as the fill pattern
  function automatic logic [31:0] load(input logic [31:0] a);
    if (mem.exists(a[31:2])) begin
      return mem[a[31:2]];
    end
    return ({a[31:2], 2'b00} * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic void store(input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] strb);
    logic [31:0] word;
    word = load(a);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = d[8*b +: 8];
      end
    end
    mem[a[31:2]] = word;
  endfunction

  // a channel moves in about three cycles of four when stalls are on
  function automatic logic go();
    return !stall_en || (($urandom % 4) != 0);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rlast    <= 1'b0;
      rdata    <= '0;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      r_busy   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      ar_count <= 0;
      aw_count <= 0;
    end else begin
      // read address
      if (!r_busy) begin
        if (arvalid && arready) begin
          r_busy   <= 1'b1;
          r_addr   <= ar.addr;
          r_left   <= ar.len;
          last_ar  <= ar;
          ar_count <= ar_count + 1;
          arready  <= 1'b0;
        end else begin
          arready <= go();
        end
      end else begin
        // read data beats, with gaps between them
        if (rvalid && rready) begin
          rvalid <= 1'b0;
          if (rlast) begin
            r_busy <= 1'b0;
          end else begin
            r_addr <= r_addr + 32'd4;
            r_left <= r_left - 8'd1;
          end
        end else if (!rvalid && go()) begin
          rvalid <= 1'b1;
          rdata  <= load(r_addr);
          rlast  <= (r_left == 8'd0);
        end
      end
      // write address and data, either order
      if (!aw_got) begin
        if (awvalid && awready) begin
          aw_got   <= 1'b1;
          last_aw  <= aw;
          aw_count <= aw_count + 1;
          awready  <= 1'b0;
        end else begin
          awready <= go();
        end
      end
      if (!w_got) begin
        if (wvalid && wready) begin
          w_got  <= 1'b1;
          last_w <= w;
          wready <= 1'b0;
        end else begin
          wready <= go();
        end
      end
      if (aw_got && w_got && !bvalid && go()) begin
        store(last_aw.addr, last_w.data, last_w.strb);
        bvalid <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
    end
  end

endmodule

// File: dv/mem_unit_asserts.sv
`timescale 1ns/1ps

module mem_unit_asserts (
  input logic             clk,
  input logic             rst,
  input mem_pkg::axi_ar_t ar,
  input logic             arvalid,
  input logic             arready,
  input mem_pkg::axi_aw_t aw,
  input logic             awvalid,
  input logic             awready,
  input mem_pkg::axi_w_t  w,
  input logic             wvalid,
  input logic             wready,
  input logic             bus_start,
  input logic             bus_done
);

  // a bus transaction is open from bus_start up to its bus_done
  logic open_txn;

  always_ff @(posedge clk) begin
    if (rst) begin
      open_txn <= 1'b0;
    end else if (bus_start) begin
      open_txn <= 1'b1;
    end else if (bus_done) begin
      open_txn <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("AR dropped or changed while stalled");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(aw))
    else $error("AW dropped or changed while stalled");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(w))
    else $error("W dropped or changed while stalled");

  done_after_start: assert property (@(posedge clk) disable iff (rst)
    bus_done |-> open_txn)
    else $error("bus_done without a preceding bus_start");

endmodule

bind axi_bridge mem_unit_asserts u_asserts (
  .clk       (clk),
  .rst       (rst),
  .ar        (ar),
  .arvalid   (arvalid),
  .arready   (arready),
  .aw        (aw),
  .awvalid   (awvalid),
  .awready   (awready),
  .w         (w),
  .wvalid    (wvalid),
  .wready    (wready),
  .bus_start (bus_start),
  .bus_done  (bus_done)
);

// File: dv/mem_unit_tb.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_unit_tb;

  // twice about 60 requests of at most about 40 cycles each
  localparam int REQ_BUDGET     = 60;
  localparam int CYCLES_PER_REQ = 40;
  localparam int TIMEOUT_CYCLES = 2 * REQ_BUDGET * CYCLES_PER_REQ + 200;

  logic             clk;
  logic             rst;
  logic             req;
  logic             wr;
  mem_pkg::size_e   size;
  logic [31:0]      addr;
  logic [31:0]      wdata;
  logic             addr_ok;
  logic             data_ok;
  logic [31:0]      rdata;
  mem_pkg::axi_ar_t ar;
  logic             arvalid;
  logic             arready;
  logic [31:0]      rdata_axi;
  logic             rlast;
  logic             rvalid;
  logic             rready;
  mem_pkg::axi_aw_t aw;
  logic             awvalid;
  logic             awready;
  mem_pkg::axi_w_t  w;
  logic             wvalid;
  logic             wready;
  logic             bvalid;
  logic             bready;
  logic             stall_en;
  int               ar_count;
  int               aw_count;
  mem_pkg::axi_ar_t last_ar;
  mem_pkg::axi_aw_t last_aw;
  mem_pkg::axi_w_t  last_w;

  int errors;
  int tests;
  int accepted;
  int done_count;
  int cycle_count;
  // expected memory words that writes changed
  logic [31:0] shadow [logic [29:0]];

  mem_unit UUT (.*);

  axi_mem_model u_mem (
    .clk      (clk),
    .rst      (rst),
    .stall_en (stall_en),
    .ar       (ar),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata_axi),
    .rlast    (rlast),
    .rvalid   (rvalid),
    .rready   (rready),
    .aw       (aw),
    .awvalid  (awvalid),
    .awready  (awready),
    .w        (w),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready),
    .ar_count (ar_count),
    .aw_count (aw_count),
    .last_ar  (last_ar),
    .last_aw  (last_aw),
    .last_w   (last_w)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (data_ok) begin
      done_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // kseg0 and kseg1 drop the top three bits
  function automatic logic [31:0] to_phys(input logic [31:0] va);
    if (va[31:30] == 2'b10) begin
      return {3'b000, va[28:0]};
    end
    return va;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] pa);
    if (shadow.exists(pa[31:2])) begin
      return shadow[pa[31:2]];
    end
    return ({pa[31:2], 2'b00} * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  // one request on the cpu side
  // lat counts cycles from acceptance to data_ok
  task automatic access(input logic is_wr, input mem_pkg::size_e sz, input logic [31:0] va,
                        input logic [31:0] wd, output logic [31:0] rd, output int lat);
    logic ok;
    ok = 1'b0;
    req = 1'b1;
    wr = is_wr;
    size = sz;
    addr = va;
    wdata = wd;
    while (!ok) begin
      ok = addr_ok;
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    accepted++;
    lat = 0;
    while (!data_ok) begin
      @(posedge clk);
      #1;
      lat++;
    end
    rd = rdata;
    @(posedge clk);
    #1;
    check_value("data_ok pulse width", {31'b0, data_ok}, 32'd0);
  endtask

  task automatic read_check(input logic [31:0] va, input int ar_delta, output int lat);
    logic [31:0] rd;
    int ar0;
    ar0 = ar_count;
    access(1'b0, mem_pkg::SIZE_WORD, va, 32'd0, rd, lat);
    check_value($sformatf("rdata @%h", va), rd, expected_word(to_phys(va)));
    check_value($sformatf("ar count @%h", va), 32'(ar_count - ar0), 32'(ar_delta));
  endtask

  task automatic write_check(input mem_pkg::size_e sz, input logic [31:0] va,
                             input logic [31:0] wd, input logic [3:0] exp_strb);
    logic [31:0] rd;
    logic [31:0] pa;
    logic [31:0] word;
    int aw0;
    int lat;
    pa = to_phys(va);
    aw0 = aw_count;
    access(1'b1, sz, va, wd, rd, lat);
    check_value("aw count", 32'(aw_count - aw0), 32'd1);
    check_value("awaddr", last_aw.addr, pa);
    check_value("awsize", {29'b0, last_aw.size}, 32'd2);
    check_value("wdata", last_w.data, wd);
    check_value("wstrb", {28'b0, last_w.strb}, {28'b0, exp_strb});
    check_value("wlast", {31'b0, last_w.last}, 32'd1);
    word = expected_word(pa);
    for (int b = 0; b < 4; b++) begin
      if (exp_strb[b]) begin
        word[8*b +: 8] = wd[8*b +: 8];
      end
    end
    shadow[pa[31:2]] = word;
  endtask

  task automatic uncached_reads(input logic [31:0] base);
    int e0;
    int lat;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      read_check(32'ha000_0100 + base + i * 32'h0f04, 1, lat);
      check_value("araddr", last_ar.addr, 32'h0000_0100 + base + i * 32'h0f04);
      check_value("arlen", {24'b0, last_ar.len}, 32'd0);
    end
    report_test("uncached read", e0);
  endtask

  task automatic cached_line_fill(input logic [31:0] base);
    int e0;
    int lat;
    e0 = errors;
    read_check(32'h8000_0044 + base, 1, lat);
    check_value("araddr", last_ar.addr, 32'h0000_0040 + base);
    check_value("arlen", {24'b0, last_ar.len}, 32'(`LINE_WORDS - 1));
    check_value("arsize", {29'b0, last_ar.size}, 32'd2);
    check_value("arburst", {30'b0, last_ar.burst}, 32'd1);
    for (int i = 0; i < `LINE_WORDS; i++) begin
      read_check(32'h8000_0040 + base + 4 * i, 0, lat);
      check_value("hit latency", 32'(lat), 32'd1);
    end
    report_test("cached line", e0);
  endtask

  task automatic sized_writes(input logic [31:0] base);
    int e0;
    int lat;
    e0 = errors;
    write_check(mem_pkg::SIZE_WORD, 32'ha000_0200 + base, 32'h1122_3344, 4'b1111);
    write_check(mem_pkg::SIZE_BYTE, 32'ha000_0201 + base, 32'h0000_ab00, 4'b0010);
    write_check(mem_pkg::SIZE_HALF, 32'ha000_0202 + base, 32'hcdef_0000, 4'b1100);
    read_check(32'ha000_0200 + base, 1, lat);
    write_check(mem_pkg::SIZE_BYTE, 32'ha000_0207 + base, 32'h7700_0000, 4'b1000);
    write_check(mem_pkg::SIZE_HALF, 32'ha000_0204 + base, 32'h0000_1234, 4'b0011);
    read_check(32'ha000_0204 + base, 1, lat);
    // no allocate on a cached write miss
    write_check(mem_pkg::SIZE_WORD, 32'h8000_0280 + base, 32'h0bad_f00d, 4'b1111);
    read_check(32'ha000_0280 + base, 1, lat);
    read_check(32'h8000_0280 + base, 1, lat);
    report_test("writes", e0);
  endtask

  task automatic write_hit_update(input logic [31:0] base);
    int e0;
    int lat;
    e0 = errors;
    read_check(32'h8000_0300 + base, 1, lat);
    write_check(mem_pkg::SIZE_WORD, 32'h8000_0304 + base, 32'h5566_7788, 4'b1111);
    write_check(mem_pkg::SIZE_BYTE, 32'h8000_0309 + base, 32'h0000_9900, 4'b0010);
    read_check(32'h8000_0304 + base, 0, lat);
    read_check(32'h8000_0308 + base, 0, lat);
    report_test("write hit", e0);
  endtask

  task automatic index_eviction(input logic [31:0] base);
    int e0;
    int lat;
    e0 = errors;
    // same index with tags that differ in address bit 11
    for (int i = 0; i < 4; i++) begin
      read_check(32'h8000_0500 + base + (i % 2) * 32'h800, 1, lat);
    end
    read_check(32'h8000_0d04 + base, 0, lat);
    report_test("evict", e0);
  endtask

  initial begin
    logic [31:0] base;
    void'($urandom(32'h9a3c_6b21));
    rst = 1'b1;
    req = 1'b0;
    wr = 1'b0;
    size = mem_pkg::SIZE_WORD;
    addr = '0;
    wdata = '0;
    stall_en = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    // second pass repeats everything under stalls in a fresh region
    for (int pass = 0; pass < 2; pass++) begin
      stall_en = (pass == 1);
      base = pass * 32'h2000;
      uncached_reads(base);
      cached_line_fill(base);
      sized_writes(base);
      write_hit_update(base);
      index_eviction(base);
    end
    check_value("data_ok count", 32'(done_count), 32'(accepted));
    $display("tests %0d, requests %0d, errors %0d", tests, accepted, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: mem_unit.f
+incdir+logic
logic/mem_pkg.sv
logic/cache_store.sv
logic/cache_ctrl.sv
logic/axi_bridge.sv
logic/mem_unit.sv
dv/axi_mem_model.sv
dv/mem_unit_asserts.sv
dv/mem_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mem_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_unit_tb -f mem_unit.f -o mem_unit_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/mem_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
